// File: sim.f
+incdir+include
+incdir+tests
hdl/gl_pkg.sv
hdl/gl_alloc_if.sv
hdl/gl_retire_if.sv
hdl/gl_dispatch.sv
hdl/graduation_list.sv
hdl/gl_commit.sv
hdl/gl_top.sv
tests/tb_gl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the graduation list testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module tb_gl -o sim_gl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_gl > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tests/tb_gl_tasks.svh
`ifndef TB_GL_TASKS_SVH
`define TB_GL_TASKS_SVH

task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic report_test(input string name, input int errors_before);
    $display("%s finished with %0d errors", name, errors - errors_before);
endtask

function automatic logic [`GL_PC_W-1:0] new_pc();
    return next_rand() & 32'hFFFF_FFFC;    // Word aligned
endfunction

// All waits start and end on a falling edge
task automatic wait_disp_ack(input logic level, output logic ok);
    int n;
    n = 0;
    while (disp_ack_o !== level && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        n++;
    end
    ok = (disp_ack_o === level);
    if (!ok) begin
        $display("Timed out at %0t waiting for disp_ack_o to go %0b", $time, level);
        errors++;
    end
endtask

task automatic wait_com_req(input logic level, output logic ok);
    int n;
    n = 0;
    while (com_req_o !== level && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        n++;
    end
    ok = (com_req_o === level);
    if (!ok) begin
        $display("Timed out at %0t waiting for com_req_o to go %0b", $time, level);
        errors++;
    end
endtask

task automatic start_dispatch(input logic [`GL_PC_W-1:0] pc, input gl_pkg::gl_op_e op,
                              input logic ex, input logic [`GL_CAUSE_W-1:0] cause);
    disp_pc_i       = pc;
    disp_op_i       = op;
    disp_ex_valid_i = ex;
    disp_ex_cause_i = cause;
    disp_req_i      = 1'b1;
endtask

// Completes the four-phase cycle and records the entry in the model
task automatic finish_dispatch(output gl_pkg::gl_index_t idx);
    ref_entry_t ent;
    logic       ok;
    wait_disp_ack(1'b1, ok);
    idx = disp_index_o;
    if (ok) begin
        expect_eq("disp_index_o", 32'(disp_index_o), 32'(next_idx));
        ent.pc    = disp_pc_i;
        ent.op    = disp_op_i;
        ent.idx   = next_idx;
        ent.ex    = disp_ex_valid_i;
        ent.cause = disp_ex_cause_i;
        ent.done  = (disp_op_i == gl_pkg::OP_STORE) || disp_ex_valid_i;
        model_q.push_back(ent);
        next_idx = next_idx + gl_pkg::gl_index_t'(1);
    end
    disp_req_i = 1'b0;
    wait_disp_ack(1'b0, ok);
endtask

task automatic dispatch_one(input logic [`GL_PC_W-1:0] pc, input gl_pkg::gl_op_e op,
                            input logic ex, input logic [`GL_CAUSE_W-1:0] cause,
                            output gl_pkg::gl_index_t idx);
    start_dispatch(pc, op, ex, cause);
    finish_dispatch(idx);
endtask

task automatic pulse_writeback(input gl_pkg::gl_index_t idx, input logic ex,
                               input logic [`GL_CAUSE_W-1:0] cause);
    int i;
    wb_valid_i = 1'b1;
    wb_index_i = idx;
    wb_ex_i    = ex;
    wb_cause_i = cause;
    @(negedge clk_i);
    wb_valid_i = 1'b0;
    wb_ex_i    = 1'b0;
    for (i = 0; i < model_q.size(); i++) begin
        if (model_q[i].idx == idx) begin
            model_q[i].done = 1'b1;
            if (ex) begin
                model_q[i].ex    = 1'b1;
                model_q[i].cause = cause;
            end
        end
    end
endtask

// Tail goes back to just past idx
task automatic pulse_flush(input gl_pkg::gl_index_t idx);
    flush_i       = 1'b1;
    flush_index_i = idx;
    @(negedge clk_i);
    flush_i = 1'b0;
    while (model_q.size() > 0 && model_q[model_q.size() - 1].idx != idx) begin
        model_q.delete(model_q.size() - 1);
    end
    next_idx = idx + gl_pkg::gl_index_t'(1);
endtask

task automatic retire_one(output logic had_ex);
    ref_entry_t exp_ent;
    logic       ok;
    had_ex = 1'b0;
    if (model_q.size() == 0) begin
        $display("Nothing left to retire in the reference queue at %0t", $time);
        errors++;
    end else begin
        exp_ent = model_q.pop_front();
        wait_com_req(1'b1, ok);
        if (ok) begin
            expect_eq("com_pc_o", 32'(com_pc_o), 32'(exp_ent.pc));
            expect_eq("com_op_o", 32'(com_op_o), 32'(exp_ent.op));
            expect_eq("com_index_o", 32'(com_index_o), 32'(exp_ent.idx));
            expect_eq("com_ex_o", 32'(com_ex_o), 32'(exp_ent.ex));
            if (exp_ent.ex) expect_eq("com_cause_o", 32'(com_cause_o), 32'(exp_ent.cause));
            com_ack_i = 1'b1;
            wait_com_req(1'b0, ok);
            com_ack_i = 1'b0;
            @(negedge clk_i);
        end
        had_ex = exp_ent.ex;
        if (exp_ent.ex) begin    // Whole list goes away
            model_q.delete();
            next_idx = '0;
        end
    end
endtask

// Oldest model exception, or none
task automatic check_exc_record();
    int         i;
    logic       found;
    ref_entry_t oldest;
    found  = 1'b0;
    oldest = '0;
    for (i = 0; i < model_q.size(); i++) begin
        if (!found && model_q[i].ex) begin
            found  = 1'b1;
            oldest = model_q[i];
        end
    end
    expect_eq("exc_valid_o", 32'(exc_valid_o), 32'(found));
    if (found) begin
        expect_eq("exc_index_o", 32'(exc_index_o), 32'(oldest.idx));
        expect_eq("exc_cause_o", 32'(exc_cause_o), 32'(oldest.cause));
    end
endtask

task automatic drain_list();
    int   i;
    logic ex;
    for (i = 0; i < model_q.size(); i++) begin
        if (!model_q[i].done) pulse_writeback(model_q[i].idx, 1'b0, 4'h0);
    end
    while (model_q.size() > 0) retire_one(ex);
    expect_eq("empty_o after drain", 32'(empty_o), 32'd1);
endtask

task automatic check_reset_state();
    int e0;
    e0 = errors;
    expect_eq("empty_o after reset", 32'(empty_o), 32'd1);
    expect_eq("full_o after reset", 32'(full_o), 32'd0);
    expect_eq("com_req_o after reset", 32'(com_req_o), 32'd0);
    expect_eq("disp_ack_o after reset", 32'(disp_ack_o), 32'd0);
    expect_eq("exc_valid_o after reset", 32'(exc_valid_o), 32'd0);
    report_test("reset state", e0);
endtask

task automatic retire_in_order();
    int                e0;
    int                i;
    int                j;
    gl_pkg::gl_index_t order [5];
    gl_pkg::gl_index_t idx;
    gl_pkg::gl_index_t tmp;
    logic              ex;
    e0 = errors;
    for (i = 0; i < 5; i++) begin
        dispatch_one(new_pc(), gl_pkg::OP_ALU, 1'b0, 4'h0, idx);
        order[i] = idx;
    end
    dispatch_one(new_pc(), gl_pkg::OP_STORE, 1'b0, 4'h0, idx);    // Never written back
    for (i = 4; i > 0; i--) begin
        j        = int'((next_rand() >> 16) % 32'(i + 1));
        tmp      = order[i];
        order[i] = order[j];
        order[j] = tmp;
    end
    for (i = 0; i < 5; i++) pulse_writeback(order[i], 1'b0, 4'h0);
    while (model_q.size() > 0) retire_one(ex);
    expect_eq("empty_o after in-order retire", 32'(empty_o), 32'd1);
    report_test("in-order retire", e0);
endtask

task automatic full_backpressure();
    int                e0;
    int                i;
    gl_pkg::gl_index_t idx;
    gl_pkg::gl_index_t freed;
    logic              ex;
    e0 = errors;
    for (i = 0; i < `GL_ENTRIES; i++) dispatch_one(new_pc(), gl_pkg::OP_ALU, 1'b0, 4'h0, idx);
    expect_eq("full_o", 32'(full_o), 32'd1);
    freed = model_q[0].idx;
    start_dispatch(new_pc(), gl_pkg::OP_LOAD, 1'b0, 4'h0);
    repeat (12) begin
        @(negedge clk_i);
        expect_eq("disp_ack_o while full", 32'(disp_ack_o), 32'd0);
    end
    pulse_writeback(freed, 1'b0, 4'h0);
    retire_one(ex);
    finish_dispatch(idx);
    expect_eq("index of the freed slot", 32'(idx), 32'(freed));
    drain_list();
    report_test("full back-pressure", e0);
endtask

task automatic oldest_exception();
    int                e0;
    int                i;
    gl_pkg::gl_index_t idx;
    e0 = errors;
    for (i = 0; i < 4; i++) dispatch_one(new_pc(), gl_pkg::OP_LOAD, 1'b0, 4'h0, idx);
    pulse_writeback(model_q[2].idx, 1'b1, 4'h5);
    check_exc_record();
    pulse_writeback(model_q[1].idx, 1'b1, 4'h3);    // Older one takes over
    check_exc_record();
    expect_eq("exc_index_o of older entry", 32'(exc_index_o), 32'(model_q[1].idx));
    expect_eq("exc_cause_o of older entry", 32'(exc_cause_o), 32'h3);
    report_test("oldest exception", e0);
endtask

task automatic exception_commit();
    int   e0;
    logic ex;
    e0 = errors;
    ex = 1'b0;
    while (!ex && model_q.size() > 0) begin
        if (!model_q[0].done) pulse_writeback(model_q[0].idx, 1'b0, 4'h0);
        retire_one(ex);
    end
    expect_eq("retired an exception", 32'(ex), 32'd1);
    expect_eq("empty_o after exception", 32'(empty_o), 32'd1);
    expect_eq("exc_valid_o after exception", 32'(exc_valid_o), 32'd0);
    report_test("exception commit", e0);
endtask

task automatic branch_flush_cut();
    int                e0;
    int                i;
    gl_pkg::gl_index_t base;
    gl_pkg::gl_index_t idx;
    e0 = errors;
    for (i = 0; i < 6; i++) dispatch_one(new_pc(), gl_pkg::OP_BRANCH, 1'b0, 4'h0, idx);
    base = model_q[0].idx;
    pulse_writeback(base + gl_pkg::gl_index_t'(4), 1'b1, 4'h7);
    check_exc_record();
    pulse_flush(base + gl_pkg::gl_index_t'(2));
    check_exc_record();
    expect_eq("exc_valid_o after flush", 32'(exc_valid_o), 32'd0);
    dispatch_one(new_pc(), gl_pkg::OP_STORE, 1'b0, 4'h0, idx);
    expect_eq("index after flush", 32'(idx), 32'(base + gl_pkg::gl_index_t'(3)));
    drain_list();
    report_test("branch flush", e0);
endtask

`endif

// File: tests/tb_gl.sv
`timescale 1ns/100ps
`include "gl_consts.svh"

module tb_gl;

    localparam int CLK_PERIOD       = 40;
    localparam int TOTAL_DISPATCHES = 26;    // Sum over all tests
    localparam int WATCHDOG_CYCLES  = TOTAL_DISPATCHES * 40 + 400;
    localparam int WAIT_LIMIT       = 100;   // Cycles for one handshake phase

    // Reference entry, one per dispatched instruction still in the list
    typedef struct packed {
        logic [`GL_PC_W-1:0]    pc;
        gl_pkg::gl_op_e         op;
        gl_pkg::gl_index_t      idx;
        logic                   ex;
        logic [`GL_CAUSE_W-1:0] cause;
        logic                   done;
    } ref_entry_t;

    logic                   clk_i;
    logic                   rstn_i;
    logic                   disp_req_i;
    logic [`GL_PC_W-1:0]    disp_pc_i;
    gl_pkg::gl_op_e         disp_op_i;
    logic                   disp_ex_valid_i;
    logic [`GL_CAUSE_W-1:0] disp_ex_cause_i;
    logic                   disp_ack_o;
    gl_pkg::gl_index_t      disp_index_o;
    logic                   wb_valid_i;
    gl_pkg::gl_index_t      wb_index_i;
    logic                   wb_ex_i;
    logic [`GL_CAUSE_W-1:0] wb_cause_i;
    logic                   flush_i;
    gl_pkg::gl_index_t      flush_index_i;
    logic                   com_req_o;
    logic [`GL_PC_W-1:0]    com_pc_o;
    gl_pkg::gl_op_e         com_op_o;
    gl_pkg::gl_index_t      com_index_o;
    logic                   com_ex_o;
    logic [`GL_CAUSE_W-1:0] com_cause_o;
    logic                   com_ack_i;
    logic                   full_o;
    logic                   empty_o;
    logic                   exc_valid_o;
    gl_pkg::gl_index_t      exc_index_o;
    logic [`GL_CAUSE_W-1:0] exc_cause_o;

    int                errors = 0;
    int                checks = 0;
    logic [31:0]       lcg_state = 32'h9299;
    ref_entry_t        model_q [$];     // Oldest entry at the front
    gl_pkg::gl_index_t next_idx;        // Tail as the list rules predict it

    gl_top dut_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .disp_req_i      (disp_req_i),
        .disp_pc_i       (disp_pc_i),
        .disp_op_i       (disp_op_i),
        .disp_ex_valid_i (disp_ex_valid_i),
        .disp_ex_cause_i (disp_ex_cause_i),
        .disp_ack_o      (disp_ack_o),
        .disp_index_o    (disp_index_o),
        .wb_valid_i      (wb_valid_i),
        .wb_index_i      (wb_index_i),
        .wb_ex_i         (wb_ex_i),
        .wb_cause_i      (wb_cause_i),
        .flush_i         (flush_i),
        .flush_index_i   (flush_index_i),
        .com_req_o       (com_req_o),
        .com_pc_o        (com_pc_o),
        .com_op_o        (com_op_o),
        .com_index_o     (com_index_o),
        .com_ex_o        (com_ex_o),
        .com_cause_o     (com_cause_o),
        .com_ack_i       (com_ack_i),
        .full_o          (full_o),
        .empty_o         (empty_o),
        .exc_valid_o     (exc_valid_o),
        .exc_index_o     (exc_index_o),
        .exc_cause_o     (exc_cause_o)
    );

    // LCG for pc values and writeback order
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    `include "tb_gl_tasks.svh"

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired at %0t, the test sequence did not finish", $time);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rstn_i          = 1'b0;
        disp_req_i      = 1'b0;
        disp_pc_i       = '0;
        disp_op_i       = gl_pkg::OP_ALU;
        disp_ex_valid_i = 1'b0;
        disp_ex_cause_i = '0;
        wb_valid_i      = 1'b0;
        wb_index_i      = '0;
        wb_ex_i         = 1'b0;
        wb_cause_i      = '0;
        flush_i         = 1'b0;
        flush_index_i   = '0;
        com_ack_i       = 1'b0;
        next_idx        = '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        check_reset_state();
        retire_in_order();
        full_backpressure();
        oldest_exception();
        exception_commit();    // Retires what oldest_exception left behind
        branch_flush_cut();    // List starts at index 0 after the full flush

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/gl_top.sv
`timescale 1ns/100ps
`include "gl_consts.svh"

module gl_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   disp_req_i,
    input  logic [`GL_PC_W-1:0]    disp_pc_i,
    input  gl_pkg::gl_op_e         disp_op_i,
    input  logic                   disp_ex_valid_i,
    input  logic [`GL_CAUSE_W-1:0] disp_ex_cause_i,
    output logic                   disp_ack_o,
    output gl_pkg::gl_index_t      disp_index_o,
    input  logic                   wb_valid_i,
    input  gl_pkg::gl_index_t      wb_index_i,
    input  logic                   wb_ex_i,
    input  logic [`GL_CAUSE_W-1:0] wb_cause_i,
    input  logic                   flush_i,
    input  gl_pkg::gl_index_t      flush_index_i,
    output logic                   com_req_o,
    output logic [`GL_PC_W-1:0]    com_pc_o,
    output gl_pkg::gl_op_e         com_op_o,
    output gl_pkg::gl_index_t      com_index_o,
    output logic                   com_ex_o,
    output logic [`GL_CAUSE_W-1:0] com_cause_o,
    input  logic                   com_ack_i,
    output logic                   full_o,
    output logic                   empty_o,
    output logic                   exc_valid_o,
    output gl_pkg::gl_index_t      exc_index_o,
    output logic [`GL_CAUSE_W-1:0] exc_cause_o
);

    gl_alloc_if      alloc_if ();
    gl_retire_if     retire_if ();
    gl_pkg::gl_exc_t exc;

    gl_dispatch u_dispatch (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .disp_req_i      (disp_req_i),
        .disp_pc_i       (disp_pc_i),
        .disp_op_i       (disp_op_i),
        .disp_ex_valid_i (disp_ex_valid_i),
        .disp_ex_cause_i (disp_ex_cause_i),
        .disp_ack_o      (disp_ack_o),
        .disp_index_o    (disp_index_o),
        .alloc           (alloc_if.dispatch)
    );

    graduation_list u_list (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .alloc         (alloc_if.list),
        .retire        (retire_if.list),
        .wb_valid_i    (wb_valid_i),
        .wb_index_i    (wb_index_i),
        .wb_ex_i       (wb_ex_i),
        .wb_cause_i    (wb_cause_i),
        .flush_i       (flush_i),
        .flush_index_i (flush_index_i),
        .full_o        (full_o),
        .empty_o       (empty_o),
        .exc_o         (exc)
    );

    gl_commit u_commit (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .retire      (retire_if.commit),
        .com_ack_i   (com_ack_i),
        .com_req_o   (com_req_o),
        .com_pc_o    (com_pc_o),
        .com_op_o    (com_op_o),
        .com_index_o (com_index_o),
        .com_ex_o    (com_ex_o),
        .com_cause_o (com_cause_o)
    );

    // Exception record out on plain status ports
    assign exc_valid_o = exc.valid;
    assign exc_index_o = exc.index;
    assign exc_cause_o = exc.cause;

endmodule

// File: hdl/gl_commit.sv
`timescale 1ns/100ps
`include "gl_consts.svh"

module gl_commit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    gl_retire_if.commit            retire,
    input  logic                   com_ack_i,
    output logic                   com_req_o,
    output logic [`GL_PC_W-1:0]    com_pc_o,
    output gl_pkg::gl_op_e         com_op_o,
    output gl_pkg::gl_index_t      com_index_o,
    output logic                   com_ex_o,
    output logic [`GL_CAUSE_W-1:0] com_cause_o
);

    gl_pkg::hs_state_e state_q;
    gl_pkg::gl_instr_t instr_q;    // Head entry on offer
    gl_pkg::gl_index_t index_q;
    logic              accept;

    assign com_req_o = (state_q == gl_pkg::HS_BUSY);
    assign accept    = com_req_o && com_ack_i;    // Ack rise, req is still high

    assign retire.pop       = accept;
    assign retire.flush_all = accept && instr_q.ex_valid;

    assign com_pc_o    = instr_q.pc;
    assign com_op_o    = instr_q.op;
    assign com_ex_o    = instr_q.ex_valid;
    assign com_cause_o = instr_q.ex_cause;
    assign com_index_o = index_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= gl_pkg::HS_IDLE;
        end else begin
            case (state_q)
                gl_pkg::HS_IDLE: begin
                    if (retire.head_valid) state_q <= gl_pkg::HS_BUSY;
                end
                gl_pkg::HS_BUSY: begin
                    if (accept) state_q <= gl_pkg::HS_ACK;
                end
                gl_pkg::HS_ACK: begin
                    // Retire stage holds ack as long as it needs
                    if (!com_ack_i) state_q <= gl_pkg::HS_WAIT_LOW;
                end
                gl_pkg::HS_WAIT_LOW: state_q <= gl_pkg::HS_IDLE;
                default:             state_q <= gl_pkg::HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == gl_pkg::HS_IDLE && retire.head_valid) begin
            instr_q <= retire.head_entry.instr;
            index_q <= retire.head_index;
        end
    end

endmodule

// File: hdl/graduation_list.sv
`timescale 1ns/100ps
`include "gl_consts.svh"

module graduation_list (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    gl_alloc_if.list               alloc,
    gl_retire_if.list              retire,
    input  logic                   wb_valid_i,
    input  gl_pkg::gl_index_t      wb_index_i,
    input  logic                   wb_ex_i,
    input  logic [`GL_CAUSE_W-1:0] wb_cause_i,
    input  logic                   flush_i,
    input  gl_pkg::gl_index_t      flush_index_i,    // Last correct entry
    output logic                   full_o,
    output logic                   empty_o,
    output gl_pkg::gl_exc_t        exc_o
);

    gl_pkg::gl_index_t      head_q;
    gl_pkg::gl_index_t      tail_q;
    gl_pkg::gl_count_t      count_q;
    gl_pkg::gl_instr_t      instr_q [`GL_ENTRIES];
    logic [`GL_ENTRIES-1:0] done_q;
    gl_pkg::gl_exc_t        exc_q;
    gl_pkg::gl_exc_t        exc_n;
    gl_pkg::gl_exc_t        exc_cand;
    logic                   grant;
    logic                   done_on_entry;
    logic                   branch_flush;
    gl_pkg::gl_index_t      keep_span;    // Age of the last correct entry

    // Distance from the head, smaller is older
    function automatic gl_pkg::gl_index_t ring_age(input gl_pkg::gl_index_t idx,
                                                   input gl_pkg::gl_index_t hd);
        return idx - hd;
    endfunction

    assign full_o   = (count_q == gl_pkg::gl_count_t'(`GL_ENTRIES));
    assign empty_o  = (count_q == '0);
    assign grant    = alloc.alloc_valid && !full_o && !flush_i && !retire.flush_all;

    assign alloc.alloc_grant = grant;
    assign alloc.alloc_index = tail_q;

    // Stores and faulting instructions never see a writeback
    assign done_on_entry = (alloc.alloc_instr.op == gl_pkg::OP_STORE) ||
                           alloc.alloc_instr.ex_valid;

    assign branch_flush = flush_i && !empty_o;
    assign keep_span    = ring_age(flush_index_i, head_q);

    assign retire.head_valid = !empty_o && done_q[head_q];
    assign retire.head_index = head_q;
    assign retire.head_entry = '{instr: instr_q[head_q], done: done_q[head_q]};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (retire.flush_all) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (branch_flush) begin
            // Keep head up to flush_index, a pop in the same cycle still counts
            head_q  <= head_q + gl_pkg::gl_index_t'(retire.pop);
            tail_q  <= flush_index_i + gl_pkg::gl_index_t'(1);
            count_q <= gl_pkg::gl_count_t'(keep_span) + gl_pkg::gl_count_t'(1)
                       - gl_pkg::gl_count_t'(retire.pop);
        end else begin
            head_q  <= head_q + gl_pkg::gl_index_t'(retire.pop);
            tail_q  <= tail_q + gl_pkg::gl_index_t'(grant);
            count_q <= count_q + gl_pkg::gl_count_t'(grant)
                       - gl_pkg::gl_count_t'(retire.pop);
        end
    end

    // Completion bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_q <= '0;
        end else begin
            if (grant) done_q[tail_q] <= done_on_entry;
            if (wb_valid_i) done_q[wb_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) instr_q[tail_q] <= alloc.alloc_instr;
        if (wb_valid_i && wb_ex_i) begin
            instr_q[wb_index_i].ex_valid <= 1'b1;
            instr_q[wb_index_i].ex_cause <= wb_cause_i;
        end
    end

    // Oldest pending exception
    always_comb begin
        exc_cand = '0;
        if (wb_valid_i && wb_ex_i) begin
            exc_cand = '{valid: 1'b1, index: wb_index_i, cause: wb_cause_i};
        end else if (grant && alloc.alloc_instr.ex_valid) begin
            // New entry is the youngest, so a writeback wins
            exc_cand = '{valid: 1'b1, index: tail_q, cause: alloc.alloc_instr.ex_cause};
        end

        exc_n = exc_q;
        if (exc_cand.valid && (!exc_q.valid ||
            ring_age(exc_cand.index, head_q) < ring_age(exc_q.index, head_q))) begin
            exc_n = exc_cand;
        end

        // Record on a squashed entry goes away
        if (branch_flush && exc_n.valid && ring_age(exc_n.index, head_q) > keep_span) begin
            exc_n = '0;
        end
        if (retire.flush_all) exc_n = '0;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exc_q <= '0;
        end else begin
            exc_q <= exc_n;
        end
    end

    assign exc_o = exc_q;

endmodule

// File: hdl/gl_dispatch.sv
`timescale 1ns/100ps
`include "gl_consts.svh"

module gl_dispatch (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   disp_req_i,
    input  logic [`GL_PC_W-1:0]    disp_pc_i,
    input  gl_pkg::gl_op_e         disp_op_i,
    input  logic                   disp_ex_valid_i,
    input  logic [`GL_CAUSE_W-1:0] disp_ex_cause_i,
    output logic                   disp_ack_o,
    output gl_pkg::gl_index_t      disp_index_o,
    gl_alloc_if.dispatch           alloc
);

    gl_pkg::hs_state_e state_q;
    logic              req_q;      // Registered request
    gl_pkg::gl_instr_t instr_q;

    assign alloc.alloc_valid = (state_q == gl_pkg::HS_BUSY);
    assign alloc.alloc_instr = instr_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q    <= gl_pkg::HS_IDLE;
            req_q      <= 1'b0;
            disp_ack_o <= 1'b0;
        end else begin
            req_q <= disp_req_i;
            case (state_q)
                gl_pkg::HS_IDLE: begin
                    if (req_q) state_q <= gl_pkg::HS_BUSY;
                end
                gl_pkg::HS_BUSY: begin
                    // Stalls here while the list is full or flushing
                    if (alloc.alloc_grant) begin
                        state_q    <= gl_pkg::HS_ACK;
                        disp_ack_o <= 1'b1;
                    end
                end
                gl_pkg::HS_ACK: begin
                    if (!req_q) begin
                        state_q    <= gl_pkg::HS_WAIT_LOW;
                        disp_ack_o <= 1'b0;
                    end
                end
                gl_pkg::HS_WAIT_LOW: begin
                    // Ack is already low here
                    if (!req_q) state_q <= gl_pkg::HS_IDLE;
                end
                default: state_q <= gl_pkg::HS_IDLE;
            endcase
        end
    end

    // Instruction and assigned index
    always_ff @(posedge clk_i) begin
        if (state_q == gl_pkg::HS_IDLE && req_q) begin
            instr_q.pc       <= disp_pc_i;
            instr_q.op       <= disp_op_i;
            instr_q.ex_valid <= disp_ex_valid_i;
            instr_q.ex_cause <= disp_ex_cause_i;
        end
        if (state_q == gl_pkg::HS_BUSY && alloc.alloc_grant) begin
            disp_index_o <= alloc.alloc_index;    // Stays put while ack is high
        end
    end

endmodule

// File: hdl/gl_retire_if.sv
`timescale 1ns/100ps

interface gl_retire_if;

    logic              head_valid;    // Not empty and head is done
    gl_pkg::gl_entry_t head_entry;
    gl_pkg::gl_index_t head_index;
    logic              pop;           // Retire the head
    logic              flush_all;     // Drop every entry and the exception record

    modport list (
        output head_valid,
        output head_entry,
        output head_index,
        input  pop,
        input  flush_all
    );

    modport commit (
        input  head_valid,
        input  head_entry,
        input  head_index,
        output pop,
        output flush_all
    );

endinterface

// File: hdl/gl_alloc_if.sv
`timescale 1ns/100ps

interface gl_alloc_if;

    logic              alloc_valid;    // Held until granted
    gl_pkg::gl_instr_t alloc_instr;
    logic              alloc_grant;    // One cycle, entry written at the next edge
    gl_pkg::gl_index_t alloc_index;    // Tail slot

    modport dispatch (
        output alloc_valid,
        output alloc_instr,
        input  alloc_grant,
        input  alloc_index
    );

    modport list (
        input  alloc_valid,
        input  alloc_instr,
        output alloc_grant,
        output alloc_index
    );

endinterface

// File: hdl/gl_pkg.sv
`include "gl_consts.svh"

package gl_pkg;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,    // Finished at dispatch
        OP_BRANCH,
        OP_CSR
    } gl_op_e;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_BUSY,
        HS_ACK,
        HS_WAIT_LOW
    } hs_state_e;

    typedef logic [`GL_IDX_W-1:0] gl_index_t;

    // One bit wider than the index, holds 0 to GL_ENTRIES
    typedef logic [$clog2(`GL_ENTRIES):0] gl_count_t;

    typedef struct packed {
        logic [`GL_PC_W-1:0]    pc;
        gl_op_e                 op;
        logic                   ex_valid;
        logic [`GL_CAUSE_W-1:0] ex_cause;
    } gl_instr_t;

    typedef struct packed {
        gl_instr_t instr;
        logic      done;
    } gl_entry_t;

    typedef struct packed {
        logic                   valid;
        gl_index_t              index;
        logic [`GL_CAUSE_W-1:0] cause;
    } gl_exc_t;

endpackage

// File: include/gl_consts.svh
`ifndef GL_CONSTS_SVH
`define GL_CONSTS_SVH

// List depth, keep it a power of two
`define GL_ENTRIES 8

// Index width, log2 of the depth
`define GL_IDX_W 3

`define GL_PC_W 32
`define GL_CAUSE_W 4

`endif
